// ==== filelist.f ====
hdl/sm4TablesPkg.sv
hdl/sm4CorePkg.sv
hdl/sm4Control.sv
hdl/sm4KeySchedule.sv
hdl/sm4DataPath.sv
hdl/sm4Core.sv
tests/sm4Core_assert.sv
tests/sm4CoreTb.sv

// ==== Makefile ====
# Verilator build and run of the SM4 core testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= sm4CoreTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/sm4_stim.txt ====
// mode key textIn expected, all hex; mode 0 encrypts, 1 decrypts.
// standard vector first, then further pairs in both directions.
0 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210 681edf34d206965e86b3e94f536e4246
1 0123456789abcdeffedcba9876543210 681edf34d206965e86b3e94f536e4246 0123456789abcdeffedcba9876543210
0 fedcba98765432100123456789abcdef 000102030405060708090a0b0c0d0e0f f766678f13f01adeac1b3ea955adb594
1 fedcba98765432100123456789abcdef f766678f13f01adeac1b3ea955adb594 000102030405060708090a0b0c0d0e0f
0 0123456789abcdeffedcba9876543210 aaaaaaaabbbbbbbbccccccccdddddddd 5ec8143de509cff7b5179f8f474b8619
0 0123456789abcdeffedcba9876543210 eeeeeeeeffffffffaaaaaaaabbbbbbbb 2f1d305a7fb17df985f81c8482192304
1 0123456789abcdeffedcba9876543210 5ec8143de509cff7b5179f8f474b8619 aaaaaaaabbbbbbbbccccccccdddddddd
1 0123456789abcdeffedcba9876543210 2f1d305a7fb17df985f81c8482192304 eeeeeeeeffffffffaaaaaaaabbbbbbbb
0 fedcba98765432100123456789abcdef aaaaaaaabbbbbbbbccccccccdddddddd c5876897e4a59bbba72a10c83872245b
1 fedcba98765432100123456789abcdef c5876897e4a59bbba72a10c83872245b aaaaaaaabbbbbbbbccccccccdddddddd
0 fedcba98765432100123456789abcdef eeeeeeeeffffffffaaaaaaaabbbbbbbb 12dd90bc2d200692b529a4155ac9e600
1 fedcba98765432100123456789abcdef 12dd90bc2d200692b529a4155ac9e600 eeeeeeeeffffffffaaaaaaaabbbbbbbb

// same result twice in a row, then decrypt straight back.
0 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210 681edf34d206965e86b3e94f536e4246
0 0123456789abcdeffedcba9876543210 0123456789abcdeffedcba9876543210 681edf34d206965e86b3e94f536e4246
1 0123456789abcdeffedcba9876543210 681edf34d206965e86b3e94f536e4246 0123456789abcdeffedcba9876543210

// ==== tests/sm4CoreTb.sv ====
//////////////////////////////////////////////////
// vectors come from tests/sm4_stim.txt, run from the root.
// spurious starts while busy use random data.
//////////////////////////////////////////////////
`default_nettype none

module sm4CoreTb;
  timeunit 1ns;
  timeprecision 1ps;
  import sm4CorePkg::*;

  localparam string STIM_FILE   = "tests/sm4_stim.txt";
  localparam int    ENC_LATENCY = ROUNDS + 1;
  localparam int    DEC_LATENCY = 2 * ROUNDS + 1;
  localparam int    WAIT_LIMIT  = 100;

  logic               clk;
  logic               rst_n;
  logic               start;
  logic               decrypt;
  logic [BLOCK_W-1:0] key;
  logic [BLOCK_W-1:0] textIn;
  logic [BLOCK_W-1:0] textOut;
  logic               done;

  logic               modeQ[$];
  logic [BLOCK_W-1:0] keyQ[$];
  logic [BLOCK_W-1:0] inQ[$];
  logic [BLOCK_W-1:0] expQ[$];
  logic [31:0]        lcgState = 32'h7a53_d474;
  int                 errorCount = 0;
  int                 checkCount = 0;
  bit                 vectorsReady = 1'b0;

  sm4Core dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .decrypt (decrypt),
    .key     (key),
    .textIn  (textIn),
    .textOut (textOut),
    .done    (done)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkValue(input string name, input logic [BLOCK_W-1:0] expected,
                            input logic [BLOCK_W-1:0] actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Mismatch on %s: expected 0x%0h, got 0x%0h", name, expected, actual);
    end
  endtask

  task automatic loadVectors();
    int                 fd;
    int                 n;
    string              line;
    logic [7:0]         modeVal;
    logic [BLOCK_W-1:0] keyVal;
    logic [BLOCK_W-1:0] inVal;
    logic [BLOCK_W-1:0] expVal;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      errorCount++;
      $display("Error: cannot open the stimulus file %s", STIM_FILE);
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      // skip comments and blank lines.
      if (n > 0 && line.len() > 1 && line.substr(0, 1) != "//")
      begin
        n = $sscanf(line, "%h %h %h %h", modeVal, keyVal, inVal, expVal);
        if (n == 4)
        begin
          modeQ.push_back(modeVal != 8'd0);
          keyQ.push_back(keyVal);
          inQ.push_back(inVal);
          expQ.push_back(expVal);
        end
        else
        begin
          errorCount++;
          $display("Error: stimulus line could not be read: %s", line);
        end
      end
    end
    $fclose(fd);
    if (keyQ.size() == 0)
    begin
      errorCount++;
      $display("Error: the stimulus file holds no vectors");
    end
  endtask

  // random start with unrelated data, or start low.
  task automatic driveWhileBusy();
    logic [31:0] rnd;
    rnd = nextRand();
    if (rnd[29:28] == 2'b00)
    begin
      start   <= 1'b1;
      decrypt <= rnd[31];
      key     <= {nextRand(), nextRand(), nextRand(), nextRand()};
      textIn  <= {nextRand(), nextRand(), nextRand(), nextRand()};
    end
    else
      start <= 1'b0;
  endtask

  task automatic runVector(input int idx);
    int          latency;
    int          cycles;
    bit          seen;
    logic [31:0] gap;
    latency = modeQ[idx] ? DEC_LATENCY : ENC_LATENCY;
    @(posedge clk);
    start   <= 1'b1;
    decrypt <= modeQ[idx];
    key     <= keyQ[idx];
    textIn  <= inQ[idx];
    // the core samples start here, cycle 0.
    @(posedge clk);
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < WAIT_LIMIT)
    begin
      if (cycles < latency - 1)
        driveWhileBusy();
      else
        start <= 1'b0;
      @(negedge clk);
      if (done)
        seen = 1'b1;
      else
      begin
        @(posedge clk);
        cycles++;
      end
    end
    if (!seen)
    begin
      errorCount++;
      start <= 1'b0;
      $display("Error: vector %0d gave no done pulse within %0d cycles", idx, WAIT_LIMIT);
      return;
    end
    checkValue("done latency", BLOCK_W'(latency), BLOCK_W'(cycles));
    checkValue("textOut", expQ[idx], textOut);
    @(posedge clk);
    @(negedge clk);
    checkValue("done", '0, BLOCK_W'(done));
    // idle gap, result must hold.
    gap = (nextRand() >> 24) % 6;
    repeat (gap) @(posedge clk);
    @(negedge clk);
    checkValue("textOut", expQ[idx], textOut);
  endtask

  initial
  begin
    rst_n   = 1'b0;
    start   = 1'b0;
    decrypt = 1'b0;
    key     = '0;
    textIn  = '0;
    loadVectors();
    vectorsReady = 1'b1;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    checkValue("done", '0, BLOCK_W'(done));
    checkValue("textOut", '0, textOut);
    for (int i = 0; i < keyQ.size(); i++)
      runVector(i);
    $display("Summary: %0d vectors, %0d checks, %0d errors",
             keyQ.size(), checkCount, errorCount);
    if (errorCount == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // watchdog, 80 cycles per vector plus reset and margin.
  initial
  begin
    wait (vectorsReady);
    repeat (keyQ.size() * 80 + 60) @(posedge clk);
    $display("Error: the run timed out before all vectors finished");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/sm4Core_assert.sv ====
//////////////////////////////////////////////////
// bound into sm4Core, checks done and textOut.
//////////////////////////////////////////////////
`default_nettype none

module sm4CoreAssert (
  input wire logic                           clk,
  input wire logic                           rst_n,
  input wire logic                           start,
  input wire logic                           done,
  input wire logic [sm4CorePkg::BLOCK_W-1:0] textOut
);
  timeunit 1ns;
  timeprecision 1ps;
  import sm4CorePkg::*;

  // sampled start to sampled rise of done.
  localparam int ENC_AGE = ROUNDS + 2;
  localparam int DEC_AGE = 2 * ROUNDS + 2;

  doneSingle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high for two cycles");

  outputHold: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(textOut) |-> $rose(done))
    else $error("textOut changed without a rising done");

  doneCause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done) |-> ($past(start, ENC_AGE) || $past(start, DEC_AGE)))
    else $error("done rose without a start 33 or 65 cycles before");

endmodule

bind sm4Core sm4CoreAssert u_assert (
  .clk     (clk),
  .rst_n   (rst_n),
  .start   (start),
  .done    (done),
  .textOut (textOut)
);

`default_nettype wire

// ==== hdl/sm4Core.sv ====
//////////////////////////////////////////////////
// iterative SM4, one round per clock.
// start ignored while busy, done is one cycle.
//////////////////////////////////////////////////
`default_nettype none

module sm4Core (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             start,
  input  wire logic                             decrypt,
  input  wire logic [sm4CorePkg::BLOCK_W-1:0]   key,
  input  wire logic [sm4CorePkg::BLOCK_W-1:0]   textIn,
  output logic [sm4CorePkg::BLOCK_W-1:0]        textOut,
  output logic                                  done
);
  import sm4CorePkg::*;

  keyCmd_e            keyCmd;
  dataCmd_e           dataCmd;
  logic [ROUND_W-1:0] round;
  logic [WORD_W-1:0]  roundKey;

  sm4Control u_control (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .decrypt (decrypt),
    .keyCmd  (keyCmd),
    .dataCmd (dataCmd),
    .round   (round),
    .done    (done)
  );

  sm4KeySchedule u_keySchedule (
    .clk      (clk),
    .rst_n    (rst_n),
    .keyCmd   (keyCmd),
    .round    (round),
    .key      (key),
    .roundKey (roundKey)
  );

  sm4DataPath u_dataPath (
    .clk      (clk),
    .rst_n    (rst_n),
    .dataCmd  (dataCmd),
    .textIn   (textIn),
    .roundKey (roundKey),
    .textOut  (textOut)
  );

endmodule

`default_nettype wire

// ==== hdl/sm4DataPath.sv ====
//////////////////////////////////////////////////
// one round per DATA_ROUND step.
// textOut only changes on DATA_OUT.
//////////////////////////////////////////////////
`default_nettype none

module sm4DataPath (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire sm4CorePkg::dataCmd_e             dataCmd,
  input  wire logic [sm4CorePkg::BLOCK_W-1:0]   textIn,
  input  wire logic [sm4CorePkg::WORD_W-1:0]    roundKey,
  output logic [sm4CorePkg::BLOCK_W-1:0]        textOut
);
  import sm4CorePkg::*;
  import sm4TablesPkg::*;

  logic [WORD_W-1:0] x0;
  logic [WORD_W-1:0] x1;
  logic [WORD_W-1:0] x2;
  logic [WORD_W-1:0] x3;
  logic [WORD_W-1:0] nextWord;

  // round function F.
  assign nextWord = x0 ^ dataT(x1 ^ x2 ^ x3 ^ roundKey);

  always_ff @(posedge clk)
  begin
    case (dataCmd)
      DATA_LOAD:
        {x0, x1, x2, x3} <= textIn;
      DATA_ROUND:
        {x0, x1, x2, x3} <= {x1, x2, x3, nextWord};
      default:
        {x0, x1, x2, x3} <= {x0, x1, x2, x3};
    endcase
  end

  // final reverse transform R.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      textOut <= '0;
    else if (dataCmd == DATA_OUT)
      textOut <= {x3, x2, x1, x0};
  end

endmodule

`default_nettype wire

// ==== hdl/sm4KeySchedule.sv ====
//////////////////////////////////////////////////
// round keys are made on the fly, none are stored.
// backward steps need the schedule at its end.
//////////////////////////////////////////////////
`default_nettype none

module sm4KeySchedule (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire sm4CorePkg::keyCmd_e              keyCmd,
  input  wire logic [sm4CorePkg::ROUND_W-1:0]   round,
  input  wire logic [sm4CorePkg::BLOCK_W-1:0]   key,
  output logic [sm4CorePkg::WORD_W-1:0]         roundKey
);
  import sm4CorePkg::*;
  import sm4TablesPkg::*;

  // k0 is the oldest word, k3 the newest.
  logic [WORD_W-1:0] k0;
  logic [WORD_W-1:0] k1;
  logic [WORD_W-1:0] k2;
  logic [WORD_W-1:0] k3;
  logic [WORD_W-1:0] fwdWord;
  logic [WORD_W-1:0] backWord;

  // K(i+4) from K(i)..K(i+3).
  assign fwdWord = k0 ^ keyT(k1 ^ k2 ^ k3 ^ CK[round]);

  // inverse step, rebuilds K(i) from K(i+1)..K(i+4).
  assign backWord = k3 ^ keyT(k0 ^ k1 ^ k2 ^ CK[round]);

  always_comb
  begin
    case (keyCmd)
      KEY_BACK:
        roundKey = k3;
      default:
        roundKey = fwdWord;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      k0 <= '0;
      k1 <= '0;
      k2 <= '0;
      k3 <= '0;
    end
    else
    begin
      case (keyCmd)
        KEY_LOAD:
          {k0, k1, k2, k3} <= key ^ FK;
        KEY_FWD:
          {k0, k1, k2, k3} <= {k1, k2, k3, fwdWord};
        KEY_BACK:
          {k0, k1, k2, k3} <= {backWord, k0, k1, k2};
        default:
        begin
          // hold.
          {k0, k1, k2, k3} <= {k0, k1, k2, k3};
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sm4Control.sv ====
//////////////////////////////////////////////////
// start is only looked at in IDLE.
// latency is 33 cycles encrypt, 65 decrypt.
//////////////////////////////////////////////////
`default_nettype none

module sm4Control (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             start,
  input  wire logic                             decrypt,
  output sm4CorePkg::keyCmd_e                   keyCmd,
  output sm4CorePkg::dataCmd_e                  dataCmd,
  output logic [sm4CorePkg::ROUND_W-1:0]        round,
  output logic                                  done
);
  import sm4CorePkg::*;

  ctrlState_e state;
  ctrlState_e nextState;
  logic       decMode;
  logic       lastRound;

  // decrypt rounds count down to zero, everything else up to 31.
  assign lastRound = (state == ROUND && decMode) ? (round == '0)
                                                 : (round == ROUND_W'(ROUNDS - 1));

  always_comb
  begin
    nextState = state;
    keyCmd    = KEY_HOLD;
    dataCmd   = DATA_HOLD;
    case (state)
      IDLE:
      begin
        if (start)
        begin
          keyCmd    = KEY_LOAD;
          dataCmd   = DATA_LOAD;
          nextState = decrypt ? EXPAND : ROUND;
        end
      end
      EXPAND:
      begin
        // walk the schedule to its end, data untouched.
        keyCmd = KEY_FWD;
        if (lastRound)
          nextState = ROUND;
      end
      ROUND:
      begin
        keyCmd  = decMode ? KEY_BACK : KEY_FWD;
        dataCmd = DATA_ROUND;
        if (lastRound)
          nextState = FINISH;
      end
      FINISH:
      begin
        dataCmd   = DATA_OUT;
        nextState = IDLE;
      end
      default:
        nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      decMode <= 1'b0;
      round   <= '0;
      done    <= 1'b0;
    end
    else
    begin
      state <= nextState;
      done  <= (state == FINISH);
      if (state == IDLE && start)
        decMode <= decrypt;
      case (state)
        IDLE:
          round <= '0;
        EXPAND:
        begin
          // index stays at 31 for the first backward round.
          if (!lastRound)
            round <= round + 1'b1;
        end
        ROUND:
          round <= decMode ? round - 1'b1 : round + 1'b1;
        default:
          round <= round;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/sm4CorePkg.sv ====
//////////////////////////////////////////////////
// sizes and step encodings of the SM4 core.
// SM4 fixes all of these, nothing is tunable.
//////////////////////////////////////////////////
`default_nettype none

package sm4CorePkg;

  localparam int WORD_W  = 32;
  localparam int BLOCK_W = 128;
  localparam int ROUNDS  = 32;
  localparam int ROUND_W = 5;

  // EXPAND is only visited when decrypting.
  typedef enum logic [1:0] {
    IDLE,
    EXPAND,
    ROUND,
    FINISH
  } ctrlState_e;

  typedef enum logic [1:0] {
    KEY_HOLD,
    KEY_LOAD,
    KEY_FWD,
    KEY_BACK
  } keyCmd_e;

  typedef enum logic [1:0] {
    DATA_HOLD,
    DATA_LOAD,
    DATA_ROUND,
    DATA_OUT
  } dataCmd_e;

endpackage

`default_nettype wire

// ==== hdl/sm4TablesPkg.sv ====
//////////////////////////////////////////////////
// fixed SM4 constants and byte/word transforms.
// table index 0 sits at the most significant end.
//////////////////////////////////////////////////
`default_nettype none

package sm4TablesPkg;

  // byte substitution, sixteen entries per row.
  localparam logic [0:255][7:0] SBOX = {
    128'hd690e9fe_cce13db7_16b614c2_28fb2c05,
    128'h2b679a76_2abe04c3_aa441326_49860699,
    128'h9c4250f4_91ef987a_33540b43_edcfac62,
    128'he4b31ca9_c908e895_80df94fa_758f3fa6,
    128'h4707a7fc_f37317ba_83593c19_e6854fa8,
    128'h686b81b2_7164da8b_f8eb0f4b_70569d35,
    128'h1e240e5e_6358d1a2_25227c3b_01217887,
    128'hd4004657_9fd32752_4c3602e7_a0c4c89e,
    128'heabf8ad2_40c738b5_a3f7f2ce_f96115a1,
    128'he0ae5da4_9b341a55_ad933230_f58cb1e3,
    128'h1df6e22e_8266ca60_c02923ab_0d534e6f,
    128'hd5db3745_defd8e2f_03ff6a72_6d6c5b51,
    128'h8d1baf92_bbddbc7f_11d95c41_1f105ad8,
    128'h0ac13188_a5cd7bbd_2d74d012_b8e5b4b0,
    128'h8969974a_0c96777e_65b9f109_c56ec684,
    128'h18f07dec_3adc4d20_79ee5f3e_d7cb3948
  };

  // round constants, four per row.
  localparam logic [0:31][31:0] CK = {
    128'h00070e15_1c232a31_383f464d_545b6269,
    128'h70777e85_8c939aa1_a8afb6bd_c4cbd2d9,
    128'he0e7eef5_fc030a11_181f262d_343b4249,
    128'h50575e65_6c737a81_888f969d_a4abb2b9,
    128'hc0c7ced5_dce3eaf1_f8ff060d_141b2229,
    128'h30373e45_4c535a61_686f767d_848b9299,
    128'ha0a7aeb5_bcc3cad1_d8dfe6ed_f4fb0209,
    128'h10171e25_2c333a41_484f565d_646b7279
  };

  // system parameter words, folded into the key at load.
  localparam logic [0:3][31:0] FK = {
    32'ha3b1bac6,
    32'h56aa3350,
    32'h677d9197,
    32'hb27022dc
  };

  function automatic logic [31:0] rotl(input logic [31:0] w, input int unsigned n);
    return (w << n) | (w >> (32 - n));
  endfunction

  // non-linear step, one S-box lookup per byte.
  function automatic logic [31:0] tauSub(input logic [31:0] a);
    return {SBOX[a[31:24]], SBOX[a[23:16]], SBOX[a[15:8]], SBOX[a[7:0]]};
  endfunction

  // round transform T.
  function automatic logic [31:0] dataT(input logic [31:0] x);
    logic [31:0] b;
    b = tauSub(x);
    return b ^ rotl(b, 2) ^ rotl(b, 10) ^ rotl(b, 18) ^ rotl(b, 24);
  endfunction

  // key expansion transform T'.
  function automatic logic [31:0] keyT(input logic [31:0] x);
    logic [31:0] b;
    b = tauSub(x);
    return b ^ rotl(b, 13) ^ rotl(b, 23);
  endfunction

endpackage

`default_nettype wire
